//--- src/mem_bus_pkg.sv
////////////////////
// data bus types
////////////////////

`default_nettype none

package mem_bus_pkg;

  // one enable per byte of the 32-bit data word
  localparam int unsigned BE_WIDTH = 4;

  // request side, driven by the LSU
  // all fields stay stable from req until gnt
  typedef struct packed {
    logic                req;    // access pending
    logic                we;     // 1 = store, 0 = load
    logic [BE_WIDTH-1:0] be;     // byte enables, lane 0 is the low byte
    logic [31:0]         addr;   // byte address, ram uses addr[31:2]
    logic [31:0]         wdata;  // already rotated into byte lanes
  } mem_req_t;

  // response side, driven by the ram
  // gnt and err are combinational, rvalid and rdata follow a grant
  // by one cycle
  typedef struct packed {
    logic        gnt;     // request accepted this cycle
    logic        err;     // access outside the ram, only with gnt
    logic        rvalid;  // response for the grant of last cycle
    logic [31:0] rdata;   // load data, zero after an errant load
  } mem_rsp_t;

endpackage

`default_nettype wire

//--- src/lsu_op_pkg.sv
////////////////////
// load/store ops
////////////////////

`default_nettype none

package lsu_op_pkg;

  // what the op does to memory
  typedef enum logic {
    LS_LOAD  = 1'b0,
    LS_STORE = 1'b1
  } ls_opcode_e;

  // access width, bit 1 means byte and bit 0 means halfword
  typedef enum logic [1:0] {
    LS_WORD = 2'd0,
    LS_HALF = 2'd1,
    LS_BYTE = 2'd2
  } ls_width_e;

  // one operation as the execute side hands it over
  typedef struct packed {
    ls_opcode_e  opcode;
    ls_width_e   width;
    logic        sign_ext;  // loads only, extend from the field msb
    logic [31:0] base;      // address is base + offset
    logic [31:0] offset;
    logic [31:0] wdata;     // stores only, right aligned
  } ls_op_t;

endpackage

`default_nettype wire

//--- src/data_ram.sv
////////////////////
// data ram
////////////////////

`timescale 1ns/1ns
`default_nettype none

module data_ram #(
  parameter int unsigned MEM_WORDS = 256  // power of two
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  mem_bus_pkg::mem_req_t mem_req_i,
  output mem_bus_pkg::mem_rsp_t mem_rsp_o,
  input  logic                  stall_i     // holds the grant off
);

  localparam int unsigned IDX_W = $clog2(MEM_WORDS);

  logic [31:0]      mem_q [MEM_WORDS];
  logic [IDX_W-1:0] idx;
  logic             out_of_range;
  logic             gnt;
  logic             rvalid_q;
  logic [31:0]      rdata_q;

  assign idx          = mem_req_i.addr[IDX_W+1:2];
  assign out_of_range = (mem_req_i.addr[31:2] >= MEM_WORDS);
  assign gnt          = mem_req_i.req && !stall_i;

  // storage, byte lanes written only on a good granted store
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      for (int w = 0; w < MEM_WORDS; w++) begin
        mem_q[w] <= '0;
      end
    end else if (gnt && mem_req_i.we && !out_of_range) begin
      for (int b = 0; b < mem_bus_pkg::BE_WIDTH; b++) begin
        if (mem_req_i.be[b]) begin
          mem_q[idx][8*b +: 8] <= mem_req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= gnt;  // every grant answers next cycle
    end
  end

  // errant loads read as zero
  always_ff @(posedge clk_i) begin
    if (gnt && !mem_req_i.we) begin
      rdata_q <= out_of_range ? 32'd0 : mem_q[idx];
    end
  end

  assign mem_rsp_o = '{
    gnt:    gnt,
    err:    gnt && out_of_range,
    rvalid: rvalid_q,
    rdata:  rdata_q
  };

endmodule

`default_nettype wire

//--- src/load_store_unit.sv
////////////////////
// load/store unit
////////////////////

`timescale 1ns/1ns
`default_nettype none

module load_store_unit (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // execute side
  input  logic                  req_ex_i,
  input  logic                  we_ex_i,
  input  logic [1:0]            type_ex_i,       // word, half or byte
  input  logic                  sign_ext_ex_i,
  input  logic [31:0]           wdata_ex_i,
  input  logic [31:0]           operand_a_i,     // base
  input  logic [31:0]           operand_b_i,     // offset
  input  logic                  addr_useincr_i,  // add operand b to the address
  input  logic                  misaligned_ex_i, // second access of a split op
  // data bus
  output mem_bus_pkg::mem_req_t mem_req_o,
  input  mem_bus_pkg::mem_rsp_t mem_rsp_i,
  // back to the execute side
  output logic [31:0]           rdata_ex_o,
  output logic                  misaligned_o,
  output logic                  ready_ex_o,
  output logic                  ready_wb_o,
  output logic                  load_err_o,
  output logic                  store_err_o,
  output logic                  busy_o
);

  localparam int unsigned BW = mem_bus_pkg::BE_WIDTH;

  typedef enum logic {
    Idle,        // no response outstanding
    WaitRValid   // a granted access waits for its response
  } lsu_state_e;

  typedef enum logic [1:0] {
    RespRegular,     // plain aligned access
    RespMisaligned,  // lower part of a split access
    RespAligned      // upper part merged with the lower one
  } resp_state_e;

  lsu_state_e  state_d, state_q;
  resp_state_e resp_state_d, resp_state_q;

  logic [1:0]      shamt;
  logic [31:0]     data_addr;
  logic [BW-1:0]   be_base;
  logic [2*BW-1:0] be_wide;  // mask before the split into two words
  logic [BW-1:0]   data_be;
  logic [31:0]     data_wdata;
  logic            data_req;
  logic            ex_valid;  // access granted this cycle

  // request properties kept for the response
  logic [BW-1:0] mask_q;
  logic [1:0]    shamt_q;
  logic [1:0]    type_q;
  logic          sign_ext_q;
  logic          we_q;
  logic [31:0]   rdata_d, rdata_q;

  // byte offset of the access
  always_comb begin
    shamt = operand_a_i[1:0];
    if (addr_useincr_i) begin
      shamt = shamt + operand_b_i[1:0];
    end
  end

  always_comb begin
    data_addr = operand_a_i;
    if (addr_useincr_i) begin
      data_addr = data_addr + operand_b_i;
      if (misaligned_ex_i) begin
        data_addr = data_addr & 32'hFFFF_FFFC;  // upper word starts at byte 0
      end
    end
  end

  // lanes past byte 3 spill into the second word
  always_comb begin
    if (type_ex_i[1]) begin
      be_base = BW'(1);
    end else if (type_ex_i[0]) begin
      be_base = BW'(3);
    end else begin
      be_base = '1;
    end
    be_wide = {{BW{1'b0}}, be_base} << shamt;
    data_be = misaligned_ex_i ? be_wide[2*BW-1:BW] : be_wide[BW-1:0];
  end

  // rotate left so each byte lands in its lane for both accesses
  always_comb begin
    case (shamt)
      2'd0:    data_wdata = wdata_ex_i;
      2'd1:    data_wdata = {wdata_ex_i[23:0], wdata_ex_i[31:24]};
      2'd2:    data_wdata = {wdata_ex_i[15:0], wdata_ex_i[31:16]};
      default: data_wdata = {wdata_ex_i[7:0], wdata_ex_i[31:8]};
    endcase
  end

  // word needs two accesses unless it is aligned
  // halfword only at offset 3
  always_comb begin
    misaligned_o = 1'b0;
    if (req_ex_i && !misaligned_ex_i) begin
      misaligned_o = ((type_ex_i == 2'b00) && (data_addr[1:0] != 2'b00))
                  || ((type_ex_i == 2'b01) && (data_addr[1:0] == 2'b11));
    end
  end

  assign ex_valid = data_req && mem_rsp_i.gnt;

  always_comb begin
    resp_state_d = resp_state_q;
    if (ex_valid && misaligned_o) begin
      resp_state_d = RespMisaligned;  // next response is the lower part
    end else if (mem_rsp_i.rvalid) begin
      resp_state_d = (resp_state_q == RespMisaligned) ? RespAligned : RespRegular;
    end
  end

  // rebuild load data in the rvalid cycle
  always_comb begin
    rdata_d = rdata_q;
    if (mem_rsp_i.rvalid && !we_q) begin
      rdata_d = mem_rsp_i.rdata
              & {{8{mask_q[3]}}, {8{mask_q[2]}}, {8{mask_q[1]}}, {8{mask_q[0]}}};
      if (resp_state_q == RespAligned) begin
        rdata_d = (rdata_d << (8 * (4 - shamt_q))) | rdata_q;  // upper bytes on top
      end else begin
        rdata_d = rdata_d >> (8 * shamt_q);
      end
      // lower part of a split load is not complete yet
      if (sign_ext_q && (resp_state_q != RespMisaligned)) begin
        if (type_q[1]) begin
          rdata_d = {{24{rdata_d[7]}}, rdata_d[7:0]};
        end else if (type_q[0]) begin
          rdata_d = {{16{rdata_d[15]}}, rdata_d[15:0]};
        end
      end
    end
  end

  // request FSM lets a new request go out with the rvalid
  always_comb begin
    state_d    = state_q;
    data_req   = 1'b0;
    ready_ex_o = 1'b1;
    ready_wb_o = 1'b1;
    case (state_q)
      Idle: begin
        data_req = req_ex_i;
        if (req_ex_i) begin
          ready_ex_o = mem_rsp_i.gnt;
          if (ex_valid) begin
            state_d = WaitRValid;
          end
        end
      end
      WaitRValid: begin
        ready_wb_o = 1'b0;
        if (mem_rsp_i.rvalid) begin
          ready_wb_o = 1'b1;
          data_req   = req_ex_i;
          if (req_ex_i) begin
            ready_ex_o = mem_rsp_i.gnt;
            state_d    = ex_valid ? WaitRValid : Idle;  // not granted, retry from Idle
          end else begin
            state_d = Idle;
          end
        end
      end
      default: state_d = Idle;
    endcase
  end

  assign mem_req_o = '{
    req:   data_req,
    we:    we_ex_i,
    be:    data_be,
    addr:  data_addr,
    wdata: data_wdata
  };

  assign rdata_ex_o  = rdata_d;  // holds the last result outside rvalid
  assign load_err_o  = ex_valid && mem_rsp_i.err && !we_ex_i;
  assign store_err_o = ex_valid && mem_rsp_i.err && we_ex_i;
  assign busy_o      = (state_q == WaitRValid) || data_req;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= Idle;
      resp_state_q <= RespRegular;
      we_q         <= 1'b0;
    end else begin
      state_q      <= state_d;
      resp_state_q <= resp_state_d;
      if (ex_valid) begin
        we_q <= we_ex_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= rdata_d;
    if (ex_valid) begin
      mask_q     <= data_be;
      shamt_q    <= shamt;
      type_q     <= type_ex_i;
      sign_ext_q <= sign_ext_ex_i;
    end
  end

endmodule

`default_nettype wire

//--- src/lsu_access_seq.sv
////////////////////
// access sequencer
////////////////////

`timescale 1ns/1ns
`default_nettype none

module lsu_access_seq (
  input  logic               clk_i,
  input  logic               rst_ni,
  // op source
  input  logic               op_valid_i,
  input  lsu_op_pkg::ls_op_t op_i,
  output logic               op_ready_o,   // final access granted
  output logic               done_o,       // final response back
  output logic [31:0]        rdata_o,
  // execute side of the lsu
  output logic               req_ex_o,
  output logic               we_ex_o,
  output logic [1:0]         type_ex_o,
  output logic               sign_ext_ex_o,
  output logic [31:0]        wdata_ex_o,
  output logic [31:0]        operand_a_o,
  output logic [31:0]        operand_b_o,
  output logic               misaligned_ex_o,
  input  logic               misaligned_i,
  input  logic               ready_ex_i,
  input  logic               ready_wb_i,
  input  logic [31:0]        rdata_ex_i,
  input  logic               mem_rvalid_i
);

  typedef enum logic {
    SeqFirst,   // first or only access of an op
    SeqSecond   // upper word of a misaligned op
  } seq_phase_e;

  seq_phase_e         phase_d, phase_q;
  lsu_op_pkg::ls_op_t op_q;       // op copy for the second access
  lsu_op_pkg::ls_op_t cur_op;
  logic               granted;
  logic               last_access;
  logic [1:0]         last_d, last_q;  // queue of last-access flags, head at bit 0
  logic [1:0]         cnt_d, cnt_q;    // queue fill level

  assign cur_op = (phase_q == SeqSecond) ? op_q : op_i;

  // the second access goes out even if op_valid_i drops meanwhile
  assign req_ex_o        = op_valid_i || (phase_q == SeqSecond);
  assign we_ex_o         = (cur_op.opcode == lsu_op_pkg::LS_STORE);
  assign type_ex_o       = cur_op.width;
  assign sign_ext_ex_o   = cur_op.sign_ext;
  assign wdata_ex_o      = cur_op.wdata;
  assign operand_b_o     = cur_op.offset;
  assign misaligned_ex_o = (phase_q == SeqSecond);

  // next word for the second access, the lsu clears the low bits
  assign operand_a_o = (phase_q == SeqSecond) ? op_q.base + 32'd4 : op_i.base;

  // lsu takes the request only when both stages are free
  assign granted     = req_ex_o && ready_ex_i && ready_wb_i;
  assign last_access = (phase_q == SeqSecond) || !misaligned_i;
  assign op_ready_o  = granted && last_access;

  always_comb begin
    phase_d = phase_q;
    if (granted) begin
      phase_d = last_access ? SeqFirst : SeqSecond;
    end
  end

  // pop on rvalid first, then push behind whatever is left
  always_comb begin
    last_d = last_q;
    cnt_d  = cnt_q;
    if (mem_rvalid_i && (cnt_q != 2'd0)) begin
      last_d = {1'b0, last_q[1]};
      cnt_d  = cnt_q - 2'd1;
    end
    if (granted) begin
      last_d[cnt_d[0]] = last_access;
      cnt_d            = cnt_d + 2'd1;
    end
  end

  assign done_o  = mem_rvalid_i && (cnt_q != 2'd0) && last_q[0];
  assign rdata_o = rdata_ex_i;  // rebuilt by the lsu in the rvalid cycle

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= SeqFirst;
      last_q  <= '0;
      cnt_q   <= '0;
    end else begin
      phase_q <= phase_d;
      last_q  <= last_d;
      cnt_q   <= cnt_d;
    end
  end

  // keep the op for the upper access
  always_ff @(posedge clk_i) begin
    if (granted && (phase_q == SeqFirst)) begin
      op_q <= op_i;
    end
  end

endmodule

`default_nettype wire

//--- src/lsu_subsys.sv
////////////////////
// lsu subsystem
////////////////////

`timescale 1ns/1ns
`default_nettype none

module lsu_subsys #(
  parameter int unsigned MEM_WORDS = 256  // ram depth in words
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               op_valid_i,
  input  lsu_op_pkg::ls_op_t op_i,
  output logic               op_ready_o,
  output logic               done_o,
  output logic [31:0]        rdata_o,
  output logic               load_err_o,
  output logic               store_err_o,
  input  logic               mem_stall_i,
  output logic               busy_o
);

  // sequencer to lsu
  logic        req_ex;
  logic        we_ex;
  logic [1:0]  type_ex;
  logic        sign_ext_ex;
  logic [31:0] wdata_ex;
  logic [31:0] operand_a;
  logic [31:0] operand_b;
  logic        misaligned_ex;
  // lsu to sequencer
  logic        misaligned;
  logic        ready_ex;
  logic        ready_wb;
  logic [31:0] rdata_ex;
  // data bus
  mem_bus_pkg::mem_req_t mem_req;
  mem_bus_pkg::mem_rsp_t mem_rsp;

  lsu_access_seq lsu_access_seq_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .op_valid_i      (op_valid_i),
    .op_i            (op_i),
    .op_ready_o      (op_ready_o),
    .done_o          (done_o),
    .rdata_o         (rdata_o),
    .req_ex_o        (req_ex),
    .we_ex_o         (we_ex),
    .type_ex_o       (type_ex),
    .sign_ext_ex_o   (sign_ext_ex),
    .wdata_ex_o      (wdata_ex),
    .operand_a_o     (operand_a),
    .operand_b_o     (operand_b),
    .misaligned_ex_o (misaligned_ex),
    .misaligned_i    (misaligned),
    .ready_ex_i      (ready_ex),
    .ready_wb_i      (ready_wb),
    .rdata_ex_i      (rdata_ex),
    .mem_rvalid_i    (mem_rsp.rvalid)
  );

  load_store_unit load_store_unit_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_ex_i        (req_ex),
    .we_ex_i         (we_ex),
    .type_ex_i       (type_ex),
    .sign_ext_ex_i   (sign_ext_ex),
    .wdata_ex_i      (wdata_ex),
    .operand_a_i     (operand_a),
    .operand_b_i     (operand_b),
    .addr_useincr_i  (1'b1),         // address is always base + offset
    .misaligned_ex_i (misaligned_ex),
    .mem_req_o       (mem_req),
    .mem_rsp_i       (mem_rsp),
    .rdata_ex_o      (rdata_ex),
    .misaligned_o    (misaligned),
    .ready_ex_o      (ready_ex),
    .ready_wb_o      (ready_wb),
    .load_err_o      (load_err_o),
    .store_err_o     (store_err_o),
    .busy_o          (busy_o)
  );

  data_ram #(
    .MEM_WORDS (MEM_WORDS)
  ) data_ram_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .mem_req_i (mem_req),
    .mem_rsp_o (mem_rsp),
    .stall_i   (mem_stall_i)
  );

endmodule

`default_nettype wire

//--- tests/tb_lsu_subsys.sv
////////////////////
// lsu testbench
////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_lsu_subsys;

  localparam int unsigned MEM_WORDS  = 256;
  localparam int unsigned MEM_BYTES  = MEM_WORDS * 4;
  localparam int unsigned BYTE_AW    = $clog2(MEM_BYTES);
  localparam int unsigned N_OPS      = 400;
  localparam int unsigned GAP_CYCLES = 5;
  // two accesses per op at 12 cycles each, plus reset and drain
  localparam int unsigned MAX_CYCLES = N_OPS * 2 * 12 + 8 + 50;
  localparam logic [31:0] SEED       = 32'h01855683;

  // expected outcome of one op, queued when its last access is granted
  typedef struct packed {
    logic        store;
    logic [1:0]  width;
    logic        sign;
    logic        exp_err;
    logic        seen_err;  // error pulse seen while the op was presented
    logic [31:0] idx;
    logic [31:0] data;      // load result after extension
  } exp_entry_t;

  logic               clk;
  logic               rst_n;
  logic               op_valid;
  lsu_op_pkg::ls_op_t op;
  logic               op_ready;
  logic               done;
  logic [31:0]        rdata;
  logic               load_err;
  logic               store_err;
  logic               mem_stall;
  logic               busy;

  logic [7:0]  model_mem [MEM_BYTES];  // byte image of the ram, little endian
  logic [31:0] lfsr;
  exp_entry_t  pending_q [$];          // granted ops waiting for done
  exp_entry_t  cur_entry;
  exp_entry_t  done_entry;
  int unsigned done_cnt;
  int unsigned mismatch_cnt;
  int unsigned other_cnt;
  int unsigned cycle_cnt;

  lsu_subsys #(
    .MEM_WORDS (MEM_WORDS)
  ) lsu_subsys_i (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .op_valid_i  (op_valid),
    .op_i        (op),
    .op_ready_o  (op_ready),
    .done_o      (done),
    .rdata_o     (rdata),
    .load_err_o  (load_err),
    .store_err_o (store_err),
    .mem_stall_i (mem_stall),
    .busy_o      (busy)
  );

  always #10 clk = ~clk;  // 20 ns period

  // one step of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // n fresh bits, one lfsr step per bit
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] val;
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  function automatic string op_name(input exp_entry_t e);
    string s;
    s = e.store ? "store" : "load";
    case (e.width)
      2'd0:    s = {s, "_word"};
      2'd1:    s = {s, "_half"};
      default: s = {s, "_byte"};
    endcase
    if (!e.store && e.sign && (e.width != 2'd0)) begin
      s = {s, "_signed"};
    end
    return $sformatf("%s #%0d", s, e.idx);
  endfunction

  task automatic report_counts;
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
  endtask

  // move to the drive point of the next cycle, new stall bit each cycle
  task automatic next_cycle;
    @(posedge clk);
    #2;
    mem_stall = (rand_bits(2) == 32'd3);  // 1 in 4
  endtask

  // pick a random op, update the model and work out the expected result
  task automatic make_op(input int unsigned k);
    logic [31:0] sel;
    logic [31:0] addr;
    logic [31:0] a;
    logic [31:0] data;
    logic        err;
    int unsigned nbytes;
    sel         = rand_bits(2);
    op.opcode   = (rand_bits(1) != 0) ? lsu_op_pkg::LS_STORE : lsu_op_pkg::LS_LOAD;
    op.width    = (sel == 32'd1) ? lsu_op_pkg::LS_HALF
                : (sel == 32'd2) ? lsu_op_pkg::LS_BYTE : lsu_op_pkg::LS_WORD;
    op.sign_ext = (rand_bits(1) != 0);
    sel = rand_bits(4);
    if (sel == 32'd15) begin
      op.base = MEM_BYTES + rand_bits(8);      // whole op past the end
    end else if (sel >= 32'd13) begin
      op.base = MEM_BYTES - 8 + rand_bits(3);  // may straddle the last word
    end else begin
      op.base = rand_bits(7);  // small window, loads often hit earlier stores
    end
    op.offset = rand_bits(3);
    op.wdata  = rand_bits(32);
    addr   = op.base + op.offset;
    nbytes = (op.width == lsu_op_pkg::LS_WORD) ? 4 : (op.width == lsu_op_pkg::LS_HALF) ? 2 : 1;
    data   = '0;
    err    = 1'b0;
    for (int unsigned i = 0; i < nbytes; i++) begin
      a = addr + i;
      if (a >= MEM_BYTES) begin
        err = 1'b1;  // this byte's word is outside the ram
      end else if (op.opcode == lsu_op_pkg::LS_STORE) begin
        model_mem[a[BYTE_AW-1:0]] = 8'(op.wdata >> (8 * i));
      end else begin
        data = data | (32'(model_mem[a[BYTE_AW-1:0]]) << (8 * i));
      end
    end
    if (op.sign_ext) begin
      if (op.width == lsu_op_pkg::LS_BYTE) begin
        data = {{24{data[7]}}, data[7:0]};
      end else if (op.width == lsu_op_pkg::LS_HALF) begin
        data = {{16{data[15]}}, data[15:0]};
      end
    end
    cur_entry = '{
      store:    (op.opcode == lsu_op_pkg::LS_STORE),
      width:    op.width,
      sign:     op.sign_ext,
      exp_err:  err,
      seen_err: 1'b0,
      idx:      k,
      data:     data
    };
    op_valid = 1'b1;
  endtask

  // hold the op until its last access is granted
  task automatic wait_ready;
    logic got;
    got = 1'b0;
    while (!got) begin
      @(negedge clk);
      if (load_err || store_err) begin
        cur_entry.seen_err = 1'b1;
        assert (store_err == cur_entry.store && load_err == !cur_entry.store) else begin
          $display("%s raised the error pulse of the other access kind", op_name(cur_entry));
          other_cnt++;
        end
      end
      got = op_ready;
      if (got) begin
        pending_q.push_back(cur_entry);
      end else begin
        next_cycle();
      end
    end
  endtask

  // no op presented, the lsu has to drain and go quiet
  task automatic idle_gap(input int unsigned cycles);
    for (int unsigned g = 0; g < cycles; g++) begin
      next_cycle();
      op_valid = 1'b0;
      @(negedge clk);
      assert (!load_err && !store_err) else begin
        $display("error pulse while no op was presented");
        other_cnt++;
      end
      if (g >= 2) begin
        assert (!busy) else begin
          $display("busy_o still high %0d cycles after the last op", g + 1);
          other_cnt++;
        end
      end
    end
  endtask

  // completion monitor, responses must come back in issue order
  always @(negedge clk) begin
    if (rst_n && done) begin
      assert (pending_q.size() != 0) else begin
        $display("done_o pulsed with no granted op left to complete");
        other_cnt++;
      end
      if (pending_q.size() != 0) begin
        done_entry = pending_q.pop_front();
        done_cnt++;
        assert (done_entry.seen_err == done_entry.exp_err) else begin
          $display("Mismatch %s error flag: expected %0b actual %0b",
                   op_name(done_entry), done_entry.exp_err, done_entry.seen_err);
          mismatch_cnt++;
        end
        if (!done_entry.store && !done_entry.exp_err) begin
          assert (rdata == done_entry.data) else begin
            $display("Mismatch %s rdata: expected %h actual %h",
                     op_name(done_entry), done_entry.data, rdata);
            mismatch_cnt++;
          end
        end
      end
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles with %0d of %0d ops completed",
             cycle_cnt, done_cnt, N_OPS);
    other_cnt++;
    report_counts();
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    op_valid     = 1'b0;
    op           = '0;
    mem_stall    = 1'b0;
    lfsr         = SEED;
    model_mem    = '{default: 8'h00};  // ram resets to zero
    done_cnt     = 0;
    mismatch_cnt = 0;
    other_cnt    = 0;
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    assert (!op_ready && !done && !load_err && !store_err && !busy) else begin
      $display("outputs not idle after reset");
      other_cnt++;
    end
    for (int unsigned k = 0; k < N_OPS; k++) begin
      next_cycle();
      make_op(k);
      wait_ready();
      if (rand_bits(3) == 32'd7) begin
        idle_gap(GAP_CYCLES);  // occasional pause between ops
      end
    end
    idle_gap(GAP_CYCLES);
    assert (done_cnt == N_OPS && pending_q.size() == 0) else begin
      $display("only %0d of %0d ops completed", done_cnt, N_OPS);
      other_cnt++;
    end
    report_counts();
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- lsu_subsys.f
src/mem_bus_pkg.sv
src/lsu_op_pkg.sv
src/data_ram.sv
src/load_store_unit.sv
src/lsu_access_seq.sv
src/lsu_subsys.sv
tests/tb_lsu_subsys.sv

//--- Makefile
# Verilator build and run for the lsu subsystem testbench

TOP := tb_lsu_subsys

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f lsu_subsys.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

lint:
	verilator --lint-only --timing --top-module $(TOP) -f lsu_subsys.f

clean:
	rm -rf obj_dir
